// ==== design/pixelPkg.sv ====
/*
 * Pixel format shared by the fog pipeline: RGBA8888 color words and
 * the helper that clamps a blended channel back into eight bits.
 */
package pixelPkg;

    // Four channels of eight bits each, channel 0 sits in the low byte
    localparam int channelWidth = 8;
    localparam int channelCount = 4;
    localparam int colorWidth = channelWidth * channelCount;

    // A weighted channel product is twice as wide as the channel itself
    localparam int productWidth = 2 * channelWidth;

    // Sum of two products plus rounding needs one carry bit on top
    localparam int blendSumWidth = productWidth + 1;

    // Channel value that stands for 1.0 in the blend arithmetic
    localparam logic [channelWidth-1:0] fullChannel = '1;

    // One RGBA8888 pixel
    typedef logic [colorWidth-1:0] color_t;

    // Takes the rounded blend sum and returns its upper channel byte.
    // When the carry bit is set the result is clamped to full scale
    function automatic logic [channelWidth-1:0] saturateChannel(
        input logic [blendSumWidth-1:0] sum
    );
        logic [channelWidth-1:0] result;
        if (sum[blendSumWidth-1])
        begin
            result = fullChannel;
        end
        else
        begin
            result = sum[productWidth-1 -: channelWidth];
        end
        return result;
    endfunction

endpackage

// ==== design/fogPkg.sv ====
/*
 * Fog pipeline word sizes: depth, fog intensity, framebuffer address
 * and the default size of the depth-indexed fog table.
 */
package fogPkg;

    // Fragment depth as it leaves the rasterizer
    localparam int depthWidth = 16;

    // Fog intensity, 16'hFFFF keeps the full fragment color and
    // 16'h0000 replaces it entirely with the fog color
    localparam int intensityWidth = 16;

    // Framebuffer address, carried through untouched
    localparam int addrWidth = 16;

    // Default table index width, the table then holds 32 entries.
    // The index is always taken from the top bits of the depth
    localparam int defaultLutAddrWidth = 5;

    typedef logic [depthWidth-1:0] depth_t;
    typedef logic [intensityWidth-1:0] intensity_t;
    typedef logic [addrWidth-1:0] pixelAddr_t;

endpackage

// ==== design/fragmentIf.sv ====
/*
 * One in-flight fragment between two pipeline stages. The producing
 * stage takes the source modport, every consumer takes sink.
 */
`timescale 1ns/100ps

interface fragmentIf
    import pixelPkg::*, fogPkg::*;
();

    // One-cycle strobe, one fragment per strobe
    logic valid;

    // Payload, meaningful only while valid is high
    color_t color;
    depth_t depth;
    pixelAddr_t address;

    // Clear for fragments that leave with their own color
    logic fogOn;

    modport source
    (
        output valid,
        output color,
        output depth,
        output address,
        output fogOn
    );

    // Consumers may ignore fields they have no use for
    modport sink
    (
        input valid,
        input color,
        input depth,
        input address,
        input fogOn
    );

endinterface

// ==== design/fragmentIngress.sv ====
/*
 * Input stage of the fog unit. Registers the incoming fragment strobe
 * and its fields onto the first internal fragment bus.
 */
`timescale 1ns/100ps

module fragmentIngress
    import pixelPkg::*, fogPkg::*;
#(
    parameter int lutAddrWidth = defaultLutAddrWidth
)
(
    input  logic       aclk,
    input  logic       rstN,
    input  logic       inValid,
    input  color_t     inColor,
    input  depth_t     inDepth,
    input  pixelAddr_t inAddr,
    input  logic       inFogOn,
    fragmentIf.source  frag
);

    // Only the table index bits of the depth matter downstream.
    // The bits below it are cleared so they do not toggle the
    // delay registers further down the pipe
    localparam int indexLsb = depthWidth - lutAddrWidth;
    localparam depth_t depthMask = depth_t'({lutAddrWidth{1'b1}}) << indexLsb;

    // Strobe register, the only state that needs a defined value
    always_ff @(posedge aclk)
    begin
        if (!rstN)
        begin
            frag.valid <= 1'b0;
        end
        else
        begin
            frag.valid <= inValid;
        end
    end

    // Payload follows the input every cycle, qualified later by valid
    always_ff @(posedge aclk)
    begin
        frag.color <= inColor;
        frag.depth <= inDepth & depthMask;
        frag.address <= inAddr;
        frag.fogOn <= inFogOn;
    end

endmodule

// ==== design/fogTable.sv ====
/*
 * Host-writable fog intensity table indexed by fragment depth. The read
 * is registered and the fragment is delayed one cycle to stay aligned.
 */
`timescale 1ns/100ps

module fogTable
    import fogPkg::*;
#(
    parameter int lutAddrWidth = defaultLutAddrWidth
)
(
    input  logic                    aclk,
    input  logic                    rstN,
    input  logic                    tableWrEn,
    input  logic [lutAddrWidth-1:0] tableWrAddr,
    input  intensity_t              tableWrData,
    fragmentIf.sink                 fragIn,
    fragmentIf.source               fragOut,
    output intensity_t              intensity
);

    localparam int tableDepth = 1 << lutAddrWidth;

    // Contents are undefined until the host writes them
    intensity_t lut [tableDepth];

    // Top bits of the depth pick the entry, no interpolation between entries
    logic [lutAddrWidth-1:0] readIndex;

    assign readIndex = fragIn.depth[depthWidth-1 -: lutAddrWidth];

    // Host writes only happen while no fragment is in flight, so a
    // write and a read of the same entry never collide
    always_ff @(posedge aclk)
    begin
        if (tableWrEn)
        begin
            lut[tableWrAddr] <= tableWrData;
        end
        intensity <= lut[readIndex];
    end

    // Fragment strobe delayed alongside the read
    always_ff @(posedge aclk)
    begin
        if (!rstN)
        begin
            fragOut.valid <= 1'b0;
        end
        else
        begin
            fragOut.valid <= fragIn.valid;
        end
    end

    // Payload delay, no reset needed
    always_ff @(posedge aclk)
    begin
        fragOut.color <= fragIn.color;
        fragOut.depth <= fragIn.depth;
        fragOut.address <= fragIn.address;
        fragOut.fogOn <= fragIn.fogOn;
    end

endmodule

// ==== design/colorInterpolator.sv ====
/*
 * Two-stage blend of two RGBA8888 colors by an intensity. Runs every
 * cycle with no strobe; callers align their own control to its latency.
 */
`timescale 1ns/100ps

module colorInterpolator
    import pixelPkg::*, fogPkg::*;
(
    input  logic       aclk,
    input  logic       rstN,
    input  intensity_t intensity,
    input  color_t     colorA,
    input  color_t     colorB,
    output color_t     mixedColor
);

    // Blend weight is the top byte of the intensity.
    // Color A gets the weight, color B gets what is left of 1.0
    logic [channelWidth-1:0] weightA;
    logic [channelWidth-1:0] weightB;

    // Stage one products, one pair per channel
    logic [productWidth-1:0] productA [channelCount];
    logic [productWidth-1:0] productB [channelCount];

    assign weightA = intensity[intensityWidth-1 -: channelWidth];

    // Cannot underflow since the weight is at most full scale
    assign weightB = fullChannel - weightA;

    // Stage one, the weighted products for every channel
    always_ff @(posedge aclk)
    begin
        for (int ch = 0; ch < channelCount; ch++)
        begin
            productA[ch] <= productWidth'(weightA)
                * productWidth'(colorA[ch * channelWidth +: channelWidth]);
            productB[ch] <= productWidth'(weightB)
                * productWidth'(colorB[ch * channelWidth +: channelWidth]);
        end
    end

    // Stage two, add the products with rounding and clamp each channel.
    // Adding 255 before the shift makes full weight return the input
    // channel exactly, e.g. (255 * A + 255) >> 8 == A
    always_ff @(posedge aclk)
    begin
        logic [blendSumWidth-1:0] sum;
        if (!rstN)
        begin
            // Output settles to black until real products have arrived
            mixedColor <= '0;
        end
        else
        begin
            for (int ch = 0; ch < channelCount; ch++)
            begin
                sum = blendSumWidth'(productA[ch])
                    + blendSumWidth'(productB[ch])
                    + blendSumWidth'(fullChannel);
                mixedColor[ch * channelWidth +: channelWidth] <= saturateChannel(sum);
            end
        end
    end

endmodule

// ==== design/pixelEgress.sv ====
/*
 * Output stage of the fog unit. Holds the fragment for the interpolator
 * latency, then registers either the fogged or the original color.
 */
`timescale 1ns/100ps

module pixelEgress
    import pixelPkg::*, fogPkg::*;
(
    input  logic       aclk,
    input  logic       rstN,
    fragmentIf.sink    frag,
    input  color_t     mixedColor,
    output logic       outValid,
    output color_t     outColor,
    output pixelAddr_t outAddr
);

    // Matches the two register stages of the interpolator
    localparam int delayDepth = 2;

    logic       validPipe [delayDepth];
    color_t     colorPipe [delayDepth];
    pixelAddr_t addrPipe  [delayDepth];
    logic       fogOnPipe [delayDepth];

    // Control half of the delay line plus the output strobe
    always_ff @(posedge aclk)
    begin
        if (!rstN)
        begin
            validPipe[0] <= 1'b0;
            validPipe[1] <= 1'b0;
            outValid <= 1'b0;
        end
        else
        begin
            validPipe[0] <= frag.valid;
            validPipe[1] <= validPipe[0];
            outValid <= validPipe[delayDepth-1];
        end
    end

    // Payload half of the delay line and the output select.
    // By the last stage mixedColor belongs to the same fragment
    always_ff @(posedge aclk)
    begin
        colorPipe[0] <= frag.color;
        addrPipe[0] <= frag.address;
        fogOnPipe[0] <= frag.fogOn;
        colorPipe[1] <= colorPipe[0];
        addrPipe[1] <= addrPipe[0];
        fogOnPipe[1] <= fogOnPipe[0];

        // Bypass fragments keep their own color
        outColor <= fogOnPipe[delayDepth-1] ? mixedColor : colorPipe[delayDepth-1];
        outAddr <= addrPipe[delayDepth-1];
    end

endmodule

// ==== design/fogUnit.sv ====
/*
 * Top level of the fog stage. Takes one fragment per cycle and returns
 * it five cycles later, blended with the fog color when fog is enabled.
 */
`timescale 1ns/100ps

module fogUnit
    import pixelPkg::*, fogPkg::*;
#(
    parameter int lutAddrWidth = defaultLutAddrWidth
)
(
    input  logic                    aclk,
    input  logic                    rstN,

    // Fragment input, one strobe per fragment
    input  logic                    inValid,
    input  color_t                  inColor,
    input  depth_t                  inDepth,
    input  pixelAddr_t              inAddr,
    input  logic                    inFogOn,

    // Global fog color, held stable while fragments are in flight
    input  color_t                  fogColor,

    // Table write strobe, only used while the pipe is empty
    input  logic                    tableWrEn,
    input  logic [lutAddrWidth-1:0] tableWrAddr,
    input  intensity_t              tableWrData,

    // Pixel output, no back-pressure
    output logic                    outValid,
    output color_t                  outColor,
    output pixelAddr_t              outAddr
);

    // Fragment after the input register and after the table read
    fragmentIf ingressFrag();
    fragmentIf tableFrag();

    intensity_t intensity;
    color_t mixedColor;

    fragmentIngress #(
        .lutAddrWidth(lutAddrWidth)
    ) i_fragmentIngress (
        .aclk(aclk),
        .rstN(rstN),
        .inValid(inValid),
        .inColor(inColor),
        .inDepth(inDepth),
        .inAddr(inAddr),
        .inFogOn(inFogOn),
        .frag(ingressFrag)
    );

    fogTable #(
        .lutAddrWidth(lutAddrWidth)
    ) i_fogTable (
        .aclk(aclk),
        .rstN(rstN),
        .tableWrEn(tableWrEn),
        .tableWrAddr(tableWrAddr),
        .tableWrData(tableWrData),
        .fragIn(ingressFrag),
        .fragOut(tableFrag),
        .intensity(intensity)
    );

    // Full intensity keeps the fragment color, zero gives the fog color
    colorInterpolator i_colorInterpolator (
        .aclk(aclk),
        .rstN(rstN),
        .intensity(intensity),
        .colorA(tableFrag.color),
        .colorB(fogColor),
        .mixedColor(mixedColor)
    );

    pixelEgress i_pixelEgress (
        .aclk(aclk),
        .rstN(rstN),
        .frag(tableFrag),
        .mixedColor(mixedColor),
        .outValid(outValid),
        .outColor(outColor),
        .outAddr(outAddr)
    );

endmodule

// ==== verification/fogUnitTb.sv ====
/*
 * Testbench for the fog unit. Replays the trace file cycle by cycle and
 * checks every output pixel, its address and its arrival cycle.
 */
`timescale 1ns/100ps

module fogUnitTb
    import pixelPkg::*, fogPkg::*;
();

    localparam int lutAddrWidth = 5;
    localparam int pipeLatency = 5;
    localparam int newlineChar = 10;
    localparam int endOfFile = -1;

    // One pixel still owed by the DUT
    typedef struct packed {
        color_t      color;
        pixelAddr_t  addr;
        logic [31:0] due;
        logic [31:0] index;
    } expect_t;

    logic aclk = 1'b0;
    logic rstN;
    logic inValid;
    color_t inColor;
    depth_t inDepth;
    pixelAddr_t inAddr;
    logic inFogOn;
    color_t fogColor;
    logic tableWrEn;
    logic [lutAddrWidth-1:0] tableWrAddr;
    intensity_t tableWrData;
    logic outValid;
    color_t outColor;
    pixelAddr_t outAddr;

    expect_t expectQueue [$];
    expect_t monitorEntry;
    int unsigned cycleCount = 0;
    int unsigned cycleLimit = 0;

    fogUnit #(
        .lutAddrWidth(lutAddrWidth)
    ) i_dut (
        .aclk(aclk),
        .rstN(rstN),
        .inValid(inValid),
        .inColor(inColor),
        .inDepth(inDepth),
        .inAddr(inAddr),
        .inFogOn(inFogOn),
        .fogColor(fogColor),
        .tableWrEn(tableWrEn),
        .tableWrAddr(tableWrAddr),
        .tableWrData(tableWrData),
        .outValid(outValid),
        .outColor(outColor),
        .outAddr(outAddr)
    );

    // 8 ns clock period
    always #4 aclk = ~aclk;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
        input logic [31:0] actual);
        if (actual !== expected)
        begin
            failRun($sformatf("ERROR %s expected %h actual %h", testName, expected, actual));
        end
    endtask

    // Drops the rest of a comment line in the trace
    task automatic skipLine(input int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != newlineChar && ch != endOfFile)
        begin
            ch = $fgetc(fd);
        end
    endtask

    // Cycle counter doubles as the watchdog
    always @(posedge aclk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit)
        begin
            failRun("Timeout, the run took more cycles than the trace allows");
        end
    end

    // Outputs are sampled on the falling edge where they are stable
    always @(negedge aclk)
    begin
        if (outValid !== 1'b0 && outValid !== 1'b1)
        begin
            failRun("outValid is unknown after reset");
        end
        else if (outValid)
        begin
            if (expectQueue.size() == 0)
            begin
                failRun("An output pixel appeared while no fragment was in flight");
            end
            else
            begin
                monitorEntry = expectQueue.pop_front();
                checkValue($sformatf("fragment %0d color", monitorEntry.index),
                    monitorEntry.color, outColor);
                checkValue($sformatf("fragment %0d address", monitorEntry.index),
                    32'(monitorEntry.addr), 32'(outAddr));
                checkValue($sformatf("fragment %0d arrival cycle", monitorEntry.index),
                    monitorEntry.due, cycleCount);
            end
        end
    end

    initial
    begin
        int fd;
        int ch;
        int code;
        int lineCount;
        logic [7:0] kind;
        logic traceDone;
        color_t expColor;
        logic [31:0] fragIndex;

        rstN = 1'b0;
        inValid = 1'b0;
        inColor = '0;
        inDepth = '0;
        inAddr = '0;
        inFogOn = 1'b0;
        fogColor = '0;
        tableWrEn = 1'b0;
        tableWrAddr = '0;
        tableWrData = '0;

        // First pass only counts lines to size the timeout
        fd = $fopen("verification/fogTrace.txt", "r");
        if (fd == 0)
        begin
            failRun("Cannot open the trace file verification/fogTrace.txt");
        end
        lineCount = 0;
        ch = $fgetc(fd);
        while (ch != endOfFile)
        begin
            if (ch == newlineChar)
            begin
                lineCount = lineCount + 1;
            end
            ch = $fgetc(fd);
        end
        $fclose(fd);
        cycleLimit = 4 * lineCount + 100;
        fd = $fopen("verification/fogTrace.txt", "r");

        repeat (4) @(posedge aclk);
        #1;
        rstN = 1'b1;

        // Every line other than a comment takes exactly one cycle
        traceDone = 1'b0;
        fragIndex = '0;
        while (!traceDone)
        begin
            code = $fscanf(fd, " %s", kind);
            if (code != 1)
            begin
                traceDone = 1'b1;
            end
            else if (kind == "#")
            begin
                skipLine(fd);
            end
            else
            begin
                @(posedge aclk);
                #1;
                inValid = 1'b0;
                tableWrEn = 1'b0;
                case (kind)
                    "W":
                    begin
                        code = $fscanf(fd, " %h %h", tableWrAddr, tableWrData);
                        if (code != 2)
                        begin
                            failRun("A table write line in the trace is malformed");
                        end
                        tableWrEn = 1'b1;
                    end
                    "C":
                    begin
                        code = $fscanf(fd, " %h", fogColor);
                        if (code != 1)
                        begin
                            failRun("A fog color line in the trace is malformed");
                        end
                    end
                    "F":
                    begin
                        code = $fscanf(fd, " %h %h %h %h %h %h", inValid, inFogOn, inDepth,
                            inColor, inAddr, expColor);
                        if (code != 6)
                        begin
                            failRun("A fragment line in the trace is malformed");
                        end
                        // The pixel is due five edges after this drive
                        if (inValid)
                        begin
                            expectQueue.push_back('{color: expColor, addr: inAddr,
                                due: cycleCount + pipeLatency, index: fragIndex});
                            fragIndex = fragIndex + 1;
                        end
                    end
                    "I":
                    begin
                        inValid = 1'b0;
                    end
                    default:
                    begin
                        failRun("The trace holds a line of unknown kind");
                    end
                endcase
            end
        end
        $fclose(fd);

        @(posedge aclk);
        #1;
        inValid = 1'b0;
        tableWrEn = 1'b0;

        // The pipe latency is fixed, so every owed pixel is out by now
        // and a late or stray strobe still reaches the monitor
        repeat (pipeLatency + 8) @(posedge aclk);

        if (expectQueue.size() != 0)
        begin
            failRun("Fragments were still expected at the end of the run");
        end
        else
        begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== verification/fogTrace.txt ====
# Columns: W addr data | C fogColor | F valid fogOn depth color addr expectedColor | I
# Values are hex and every line that is not a comment takes one clock cycle
I
I
I
W 00 FFFF
W 01 0000
W 02 8000
W 03 4000
W 1F C000
C 40806020
I
# Full intensity keeps the fragment, zero intensity gives the fog color
F 1 1 0123 11223344 0100 11223344
F 1 1 0A00 AABBCCDD 0101 40806020
# Mid intensities across several table entries
F 1 1 1234 FF00807F 0102 A0407050
F 1 1 1FFF 00FF1080 0103 30A04C38
F 1 1 F800 80808080 0104 70807868
F 0 1 0000 FFFFFFFF 0000 00000000
# Bypass ignores table and fog color
F 1 0 1000 DEADBEEF 0105 DEADBEEF
F 1 0 0800 01020304 0106 01020304
I
I
I
I
I
# White fog and a rewritten entry
C FFFFFFFF
W 02 0000
I
F 1 1 1000 12345678 0200 FFFFFFFF
F 1 1 0800 00000000 0201 FFFFFFFF
F 1 1 07FF 5A5A5A5A 0202 5A5A5A5A
F 1 1 1800 00000000 0203 BFBFBFBF
F 1 0 F800 0F0F0F0F 0204 0F0F0F0F
I
I

// ==== fogUnit.f ====
design/pixelPkg.sv
design/fogPkg.sv
design/fragmentIf.sv
design/fragmentIngress.sv
design/fogTable.sv
design/colorInterpolator.sv
design/pixelEgress.sv
design/fogUnit.sv
verification/fogUnitTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the fog unit testbench with Verilator and runs it.
# Exits with status 0 only when the pass message shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f fogUnit.f --top-module fogUnitTb -o fogUnitSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

simOutput=$(./obj_dir/fogUnitSim 2>&1)
runStatus=$?
printf '%s\n' "$simOutput"

if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if printf '%s\n' "$simOutput" | grep -qx "Testbench passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
